// ==== build.f ====
+incdir+include
logic/sfir_pkg.sv
logic/sfir_delay_line.sv
logic/sfir_element.sv
logic/sfir_top.sv
bench/sfir_props.sv
bench/sfir_tb.sv

// ==== Bender.yml ====
package:
  name: sfir

export_include_dirs:
  - include

sources:
  - logic/sfir_pkg.sv
  - logic/sfir_delay_line.sv
  - logic/sfir_element.sv
  - logic/sfir_top.sv
  - target: test
    files:
      - bench/sfir_props.sv
      - bench/sfir_tb.sv

// ==== bench/sfir_tb.sv ====
`include "sfir_defs.svh"

module sfir_tb
    import sfir_pkg::*;
;

    // ==================================================
    // test lengths and run limit
    // ==================================================
    localparam int TAPS          = 2 * `SFIR_TAP_NUM;
    localparam int LAT           = `SFIR_LATENCY;
    localparam int RESET_CYCLES  = 16;
    localparam int FLUSH_LEN     = TAPS + LAT;
    localparam int IMPULSE_LEN   = TAPS + LAT + 4;
    localparam int STEP_LEN      = TAPS + LAT + 8;
    localparam int RANDOM_LEN    = 200;
    localparam int STALL_LEN     = 150;
    localparam int STALL_MAX_GAP = 3;
    localparam int RESET_PRE_LEN = 40;
    localparam int EXTREME_LEN   = 64;

    localparam int TEST_CYCLES = RESET_CYCLES + IMPULSE_LEN
        + STEP_LEN + FLUSH_LEN
        + RANDOM_LEN + FLUSH_LEN
        + STALL_LEN * (1 + STALL_MAX_GAP) + FLUSH_LEN
        + RESET_PRE_LEN + RESET_CYCLES + IMPULSE_LEN
        + EXTREME_LEN + FLUSH_LEN;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + TEST_CYCLES / 4 + 32;

    localparam sample_t STEP_VALUE = 16'sd1000;

    logic    clk_i = 1'b0;
    logic    arst_n_i;
    logic    en_i;
    sample_t data_i;
    acc_t    fir_o;

    integer      seed = 32'h4459_920c;
    int unsigned cycle_count = 0;
    int          error_count = 0;

    sample_t hist [TAPS];  // hist[0] is the newest enabled sample
    acc_t    exp_q [$];    // expected outputs in order
    acc_t    last_exp;     // value fir_o must hold through a stall

    always #2 clk_i = ~clk_i;

    sfir_top dut0 (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .en_i    (en_i),
        .data_i  (data_i),
        .fir_o   (fir_o)
    );

    bind sfir_top sfir_props props0 (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .en_i    (en_i),
        .data_i  (data_i),
        .fir_i   (fir_o)
    );

    // ==================================================
    // failure handling
    // ==================================================
    task automatic stop_with_failure();
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_acc(input acc_t expected, input acc_t actual, input string name);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s: expected %h, got %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles, the tests did not finish", cycle_count);
            stop_with_failure();
        end
    end

    always @(negedge clk_i) begin
        if (dut0.props0.fail_count != 0) begin
            $display("a bound assertion on sfir_top failed");
            stop_with_failure();
        end
    end

    // ==================================================
    // reference model
    // ==================================================
    function automatic coef_t coef_at(input int k);
        if (k < `SFIR_TAP_NUM) begin
            return SFIR_COEF[k];
        end
        return SFIR_COEF[TAPS-1-k];  // mirrored half
    endfunction

    function automatic acc_t impulse_tap(input int m);
        if (m < TAPS) begin
            return acc_t'(coef_at(m));
        end
        return '0;
    endfunction

    function automatic acc_t coef_sum();
        acc_t total;
        total = '0;
        for (int k = 0; k < `SFIR_TAP_NUM; k++) begin
            total = total + acc_t'(SFIR_COEF[k]);
        end
        return total;
    endfunction

    task automatic model_reset();
        for (int k = 0; k < TAPS; k++) begin
            hist[k] = '0;
        end
        exp_q.delete();
        repeat (LAT) exp_q.push_back('0);  // outputs before the first sample lands
        last_exp = '0;
    endtask

    task automatic model_push(input sample_t value);
        acc_t y;
        for (int k = TAPS - 1; k > 0; k--) begin
            hist[k] = hist[k-1];
        end
        hist[0] = value;
        y = '0;
        for (int k = 0; k < TAPS; k++) begin
            y = y + acc_t'(hist[k]) * acc_t'(coef_at(k));
        end
        exp_q.push_back(y);
    endtask

    // ==================================================
    // stimulus
    // ==================================================
    // one clock cycle, driven and checked on falling edges
    task automatic drive_sample(input sample_t value, input logic enable);
        acc_t expected;
        data_i = value;
        en_i   = enable;
        @(posedge clk_i);
        @(negedge clk_i);
        if (enable) begin
            model_push(value);
            expected = exp_q.pop_front();
        end else begin
            expected = last_exp;  // stalled, output holds
        end
        check_acc(expected, fir_o, "fir_o");
        last_exp = expected;
    endtask

    task automatic flush_pipeline();
        repeat (FLUSH_LEN) drive_sample('0, 1'b1);
    endtask

    task automatic apply_reset();
        arst_n_i = 1'b0;
        en_i     = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk_i);
            check_acc('0, fir_o, "fir_o");
        end
        arst_n_i = 1'b1;
        model_reset();
    endtask

    // ==================================================
    // directed tests
    // ==================================================
    // needs an empty history, so only right after reset
    task automatic impulse_response();
        for (int i = 0; i < IMPULSE_LEN; i++) begin
            drive_sample((i == 0) ? sample_t'(1) : sample_t'(0), 1'b1);
            if (i >= LAT) begin
                check_acc(impulse_tap(i - LAT), fir_o, "fir_o");
            end
        end
    endtask

    task automatic step_response();
        repeat (STEP_LEN) drive_sample(STEP_VALUE, 1'b1);
        check_acc(acc_t'(STEP_VALUE) * coef_sum() * 2, fir_o, "fir_o");  // settled value
        flush_pipeline();
    endtask

    task automatic random_stream();
        repeat (RANDOM_LEN) drive_sample(sample_t'($random(seed)), 1'b1);
        flush_pipeline();
    endtask

    task automatic stalled_stream();
        int gap;
        for (int i = 0; i < STALL_LEN; i++) begin
            gap = $random(seed) & 7;
            if (gap > STALL_MAX_GAP) begin
                gap = 0;
            end
            repeat (gap) drive_sample(sample_t'($random(seed)), 1'b0);  // ignored input
            drive_sample(sample_t'($random(seed)), 1'b1);
        end
        flush_pipeline();
    endtask

    task automatic reset_mid_stream();
        repeat (RESET_PRE_LEN) drive_sample(sample_t'($random(seed)), 1'b1);
        apply_reset();
        impulse_response();
    endtask

    task automatic full_scale_swing();
        for (int i = 0; i < EXTREME_LEN; i++) begin
            drive_sample((i % 2 == 0) ? 16'sh7fff : 16'sh8000, 1'b1);
        end
        flush_pipeline();
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        arst_n_i = 1'b1;
        en_i     = 1'b0;
        data_i   = '0;
        #1 arst_n_i = 1'b0;  // clean falling edge for the async reset
        repeat (RESET_CYCLES) @(negedge clk_i);
        arst_n_i = 1'b1;
        model_reset();

        impulse_response();
        step_response();
        random_stream();
        stalled_stream();
        reset_mid_stream();
        full_scale_swing();

        if (error_count == 0 && dut0.props0.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== bench/sfir_props.sv ====
module sfir_props
    import sfir_pkg::*;
(
    input logic    clk_i,
    input logic    arst_n_i,
    input logic    en_i,
    input sample_t data_i,
    input acc_t    fir_i
);

    int unsigned fail_count = 0;  // failed assertions so far

    // ==================================================
    // stall behaviour
    // ==================================================
    // a low enable at one edge must leave the output untouched
    hold_in_stall: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !en_i |=> $stable(fir_i)
    ) else begin
        $error("fir_o changed on a cycle with en_i low");
        fail_count++;
    end

    // ==================================================
    // reset and input sanity
    // ==================================================
    zero_in_reset: assert property (
        @(posedge clk_i)
        !arst_n_i |-> (fir_i == '0)
    ) else begin
        $error("fir_o is not zero while reset is active");
        fail_count++;
    end

    known_data_in: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        en_i |-> !$isunknown(data_i)
    ) else begin
        $error("data_i has unknown bits while en_i is high");
        fail_count++;
    end

endmodule

// ==== logic/sfir_top.sv ====
`include "sfir_defs.svh"

module sfir_top
    import sfir_pkg::*;
(
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  logic    en_i,
    input  sample_t data_i,
    output acc_t    fir_o
);

    // The pre-adder of element k sees the forward sample after 2k+2
    // registers. One stage beyond the full filter length in the mirror
    // line puts each mirror sample on the tap that matches its
    // forward partner, so both halves of the response line up.
    localparam int MIRROR_DEPTH = 2 * `SFIR_TAP_NUM + 1;

    sample_t    mirror;                    // oldest sample, fanned out
    sfir_casc_t casc [`SFIR_TAP_NUM+1];    // casc[k] enters element k

    // ==================================================
    // mirror sample stream
    // ==================================================
    sfir_delay_line #(
        .DEPTH(MIRROR_DEPTH)
    ) delay_line0 (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .en_i    (en_i),
        .data_i  (data_i),
        .data_o  (mirror)
    );

    // ==================================================
    // systolic element chain
    // ==================================================
    assign casc[0].data = data_i;
    assign casc[0].sum  = '0;  // chain starts from zero

    for (genvar k = 0; k < `SFIR_TAP_NUM; k++) begin : g_tap
        sfir_element #(
            .COEF(SFIR_COEF[k])
        ) element (
            .clk_i   (clk_i),
            .arst_n_i(arst_n_i),
            .en_i    (en_i),
            .casc_i  (casc[k]),
            .mirror_i(mirror),
            .casc_o  (casc[k+1])
        );
    end

    // ==================================================
    // output
    // ==================================================
    assign fir_o = casc[`SFIR_TAP_NUM].sum;  // last partial sum is the result

endmodule

// ==== logic/sfir_element.sv ====
module sfir_element
    import sfir_pkg::*;
#(
    parameter coef_t COEF = '0
) (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       en_i,
    input  sfir_casc_t casc_i,
    input  sample_t    mirror_i,
    output sfir_casc_t casc_o
);

    sample_t fwd_q1;
    sample_t fwd_q2;
    pre_t    pre_q;
    prod_t   prod_q;
    acc_t    sum_q;

    // ==================================================
    // forward sample path
    // ==================================================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fwd_q1 <= '0;
            fwd_q2 <= '0;
        end else if (en_i) begin
            fwd_q1 <= casc_i.data;
            fwd_q2 <= fwd_q1;  // also feeds the pre-adder
        end
    end

    // ==================================================
    // pre-add, multiply, cascade add
    // ==================================================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pre_q <= '0;
        end else if (en_i) begin
            pre_q <= pre_t'(fwd_q2) + pre_t'(mirror_i);  // sample plus its mirror
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prod_q <= '0;
        end else if (en_i) begin
            prod_q <= pre_q * COEF;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sum_q <= '0;
        end else if (en_i) begin
            sum_q <= casc_i.sum + acc_t'(prod_q);  // sign extended product
        end
    end

    assign casc_o.data = fwd_q2;
    assign casc_o.sum  = sum_q;

endmodule

// ==== logic/sfir_delay_line.sv ====
module sfir_delay_line
    import sfir_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  logic    en_i,
    input  sample_t data_i,
    output sample_t data_o
);

    // ==================================================
    // shift register
    // ==================================================
    sample_t taps_q [DEPTH];  // taps_q[0] holds the newest sample

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                taps_q[i] <= '0;
            end
        end else if (en_i) begin
            taps_q[0] <= data_i;
            for (int i = 1; i < DEPTH; i++) begin
                taps_q[i] <= taps_q[i-1];  // shift toward the oldest
            end
        end
    end

    // ==================================================
    // output
    // ==================================================
    assign data_o = taps_q[DEPTH-1];  // oldest sample

endmodule

// ==== logic/sfir_pkg.sv ====
`include "sfir_defs.svh"

package sfir_pkg;

    // ==================================================
    // scalar types
    // ==================================================
    typedef logic signed [`SFIR_DATA_WIDTH-1:0] sample_t;
    typedef logic signed [`SFIR_COEF_WIDTH-1:0] coef_t;
    typedef logic signed [`SFIR_ACC_WIDTH-1:0]  acc_t;

    // pre-adder output, one bit wider than a sample
    typedef logic signed [`SFIR_DATA_WIDTH:0] pre_t;

    // full product of pre-add sum and coefficient
    typedef logic signed [`SFIR_DATA_WIDTH+`SFIR_COEF_WIDTH:0] prod_t;

    // ==================================================
    // cascade between neighbouring elements
    // ==================================================
    typedef struct packed {
        sample_t data;  // forward sample
        acc_t    sum;   // partial sum
    } sfir_casc_t;

    // ==================================================
    // coefficient table
    // ==================================================
    // Only the first half of the symmetric response is stored. Entry 0 is
    // the outer tap, the last entry sits next to the center of the filter.
    localparam coef_t SFIR_COEF [0:`SFIR_TAP_NUM-1] = '{
        16'sd182,
        -16'sd288,
        16'sd498,
        -16'sd686,
        16'sd940,
        -16'sd1432,
        16'sd3590,
        16'sd11262
    };

endpackage

// ==== include/sfir_defs.svh ====
`ifndef SFIR_DEFS_SVH
`define SFIR_DEFS_SVH

// ==================================================
// filter dimensions
// ==================================================
`define SFIR_TAP_NUM     8   // unique coefficients, filter length is twice this
`define SFIR_DATA_WIDTH  16
`define SFIR_COEF_WIDTH  16

// data + coef + pre-add bit + growth over the tap sum
`define SFIR_ACC_WIDTH   (`SFIR_DATA_WIDTH + `SFIR_COEF_WIDTH + 1 + 4)

// enabled cycles from a sample entering to its first output
`define SFIR_LATENCY     (`SFIR_TAP_NUM + 3)

`endif
